// ==== verilog/cpu_pkg.sv ====
/* shared cpu definitions: widths, access lengths, i/o addresses,
   opcodes, decoded operations and the instruction word views */
package cpu_pkg;
    localparam int xlen = 32;

    // access length holds the byte count minus one
    typedef logic [1:0] len_t;
    localparam len_t len_b = 2'd0;
    localparam len_t len_h = 2'd1;
    localparam len_t len_w = 2'd3;

    // i/o port: byte output and program stop
    localparam logic [xlen-1:0] io_base = 32'h0003_0000;
    localparam logic [xlen-1:0] io_stop = 32'h0003_0004;

    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_reg    = 7'b0110011;

    typedef enum logic [5:0] {
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_lbu, op_lhu,
        op_sb, op_sh, op_sw,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and
    } op_t;

    // r/i view, imm also carries funct7 and rs2
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } ri_view_t;

    // s/b view with the split immediate
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } sb_view_t;

    typedef union packed {
        ri_view_t ri;
        sb_view_t sb;
    } inst_u;
endpackage

// ==== verilog/memctrl.sv ====
/* memory controller: serializes fetch and load/store requests
   into byte accesses and stalls output writes while the i/o buffer is full */
module memctrl (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     rdy_in,
    input  logic                     io_buffer_full,
    input  logic [7:0]               mem_din,
    input  logic                     if_en,
    input  logic [cpu_pkg::xlen-1:0] if_addr,
    input  logic                     ls_en,
    input  logic                     ls_wr,
    input  cpu_pkg::len_t            ls_len,
    input  logic [cpu_pkg::xlen-1:0] ls_addr,
    input  logic [cpu_pkg::xlen-1:0] ls_data,
    output logic [7:0]               mem_dout,
    output logic [cpu_pkg::xlen-1:0] mem_a,
    output logic                     mem_wr,
    output logic                     if_done,
    output logic [cpu_pkg::xlen-1:0] if_inst,
    output logic                     ls_done,
    output logic [cpu_pkg::xlen-1:0] ls_rdata
);
    // request in progress
    logic                     busy;
    logic                     cur_if;
    logic                     cur_wr;
    cpu_pkg::len_t            cur_len;
    logic [cpu_pkg::xlen-1:0] cur_addr;
    logic [cpu_pkg::xlen-1:0] cur_data;
    logic [2:0]               cnt;
    // read byte on its way back
    logic                     rd_pend;
    logic [1:0]               rd_idx;
    logic [cpu_pkg::xlen-1:0] rd_buf;
    logic [cpu_pkg::xlen-1:0] rd_word;

    logic                     act_valid;
    logic                     act_wr;
    cpu_pkg::len_t            act_len;
    logic [cpu_pkg::xlen-1:0] act_addr;
    logic [cpu_pkg::xlen-1:0] act_data;
    logic [1:0]               idx;
    logic [1:0]               bus_idx;
    logic                     stall;
    logic                     advance;

    always_comb begin
        if (busy) begin
            act_valid = cnt <= {1'b0, cur_len};
            act_wr = cur_wr;
            act_len = cur_len;
            act_addr = cur_addr;
            act_data = cur_data;
            idx = cnt[1:0];
        end else begin
            // fetch wins when both are asking
            act_valid = if_en || ls_en;
            act_wr = !if_en && ls_wr;
            act_len = if_en ? cpu_pkg::len_w : ls_len;
            act_addr = if_en ? if_addr : ls_addr;
            act_data = ls_data;
            idx = 2'd0;
        end
    end

    // paused: re-present the pending read so its byte comes back again
    assign bus_idx = (!rdy_in && rd_pend) ? rd_idx : idx;
    assign mem_a = act_addr + {{(cpu_pkg::xlen - 2){1'b0}}, bus_idx};
    assign mem_dout = act_data[{idx, 3'b000} +: 8];

    assign stall = act_valid && act_wr && io_buffer_full && mem_a == cpu_pkg::io_base;
    assign advance = rdy_in && act_valid && !stall;
    assign mem_wr = advance && act_wr;

    // little-endian assembly of the returning byte
    always_comb begin
        rd_word = rd_buf;
        rd_word[{rd_idx, 3'b000} +: 8] = mem_din;
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            busy <= 1'b0;
            cnt <= 3'd0;
            rd_pend <= 1'b0;
            if_done <= 1'b0;
            ls_done <= 1'b0;
        end else if (rdy_in) begin
            if_done <= 1'b0;
            ls_done <= 1'b0;
            rd_pend <= advance && !act_wr;
            rd_idx <= idx;
            if (rd_pend) begin
                rd_buf <= rd_word;
                if (rd_idx == cur_len) begin
                    busy <= 1'b0;
                    if (cur_if) begin
                        if_inst <= rd_word;
                        if_done <= 1'b1;
                    end else begin
                        ls_rdata <= rd_word;
                        ls_done <= 1'b1;
                    end
                end
            end
            // a new request is taken even while its write is held back
            if (!busy && act_valid) begin
                cur_if <= if_en;
                cur_wr <= act_wr;
                cur_len <= act_len;
                cur_addr <= act_addr;
                cur_data <= act_data;
                rd_buf <= '0;
                cnt <= 3'd0;
                busy <= 1'b1;
            end
            if (advance) begin
                cnt <= {1'b0, idx} + 3'd1;
                // writes finish with their last byte
                if (act_wr && idx == act_len) begin
                    busy <= 1'b0;
                    ls_done <= 1'b1;
                end else begin
                    busy <= 1'b1;
                end
            end
        end
    end
endmodule

// ==== verilog/fetcher.sv ====
/* fetcher: program counter, instruction register and
   the fetch, execute and memory phase sequencer */
module fetcher (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     rdy_in,
    input  logic                     if_done,
    input  logic [cpu_pkg::xlen-1:0] if_inst,
    input  logic                     ls_done,
    input  logic                     mem_op,
    input  logic [cpu_pkg::xlen-1:0] next_pc,
    output logic                     if_en,
    output logic [cpu_pkg::xlen-1:0] if_addr,
    output cpu_pkg::inst_u           inst,
    output logic [cpu_pkg::xlen-1:0] pc,
    output logic                     exec_en,
    output logic                     commit
);
    typedef enum logic [1:0] {s_idle, s_fetch, s_exec, s_mem} state_t;

    state_t state;

    assign if_addr = pc;
    // end of instruction, after exec or when its memory access is done
    assign commit = (state == s_exec && !mem_op) || (state == s_mem && ls_done);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= s_idle;
            pc <= '0;
            if_en <= 1'b0;
            exec_en <= 1'b0;
        end else if (rdy_in) begin
            if_en <= 1'b0;
            exec_en <= 1'b0;
            case (state)
                s_idle: begin
                    if_en <= 1'b1;
                    state <= s_fetch;
                end
                s_fetch: begin
                    if (if_done) begin
                        inst <= if_inst;
                        exec_en <= 1'b1;
                        state <= s_exec;
                    end
                end
                s_exec: begin
                    if (mem_op) state <= s_mem;
                end
                default: ;
            endcase
            // next fetch starts right away
            if (commit) begin
                pc <= next_pc;
                if_en <= 1'b1;
                state <= s_fetch;
            end
        end
    end
endmodule

// ==== verilog/decoder.sv ====
/* instruction decoder: operation, register names and immediate */
module decoder (
    input  cpu_pkg::inst_u           inst,
    output cpu_pkg::op_t             op,
    output logic [4:0]               rd,
    output logic [4:0]               rs1,
    output logic [4:0]               rs2,
    output logic [cpu_pkg::xlen-1:0] imm
);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       valid;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign f3 = inst.ri.funct3;
    assign f7 = inst.ri.imm[11:5];

    // immediates pulled from both views of the word
    assign imm_i = {{20{inst.ri.imm[11]}}, inst.ri.imm};
    assign imm_s = {{20{inst.sb.imm_hi[6]}}, inst.sb.imm_hi, inst.sb.imm_lo};
    assign imm_b = {{19{inst.sb.imm_hi[6]}}, inst.sb.imm_hi[6], inst.sb.imm_lo[0],
                    inst.sb.imm_hi[5:0], inst.sb.imm_lo[4:1], 1'b0};
    assign imm_u = {inst.ri.imm, inst.ri.rs1, f3, 12'd0};
    assign imm_j = {{11{inst.ri.imm[11]}}, inst.ri.imm[11], inst.ri.rs1, f3,
                    inst.ri.imm[0], inst.ri.imm[10:1], 1'b0};

    always_comb begin
        valid = 1'b1;
        op = cpu_pkg::op_addi;
        rd = inst.ri.rd;
        rs1 = inst.ri.rs1;
        rs2 = inst.sb.rs2;
        imm = imm_i;
        case (inst.ri.opcode)
            cpu_pkg::opc_lui: begin
                op = cpu_pkg::op_lui;
                imm = imm_u;
            end
            cpu_pkg::opc_auipc: begin
                op = cpu_pkg::op_auipc;
                imm = imm_u;
            end
            cpu_pkg::opc_jal: begin
                op = cpu_pkg::op_jal;
                imm = imm_j;
            end
            cpu_pkg::opc_jalr: begin
                op = cpu_pkg::op_jalr;
                valid = f3 == 3'd0;
            end
            cpu_pkg::opc_branch: begin
                imm = imm_b;
                case (f3)
                    3'd0: op = cpu_pkg::op_beq;
                    3'd1: op = cpu_pkg::op_bne;
                    3'd4: op = cpu_pkg::op_blt;
                    3'd5: op = cpu_pkg::op_bge;
                    3'd6: op = cpu_pkg::op_bltu;
                    3'd7: op = cpu_pkg::op_bgeu;
                    default: valid = 1'b0;
                endcase
            end
            cpu_pkg::opc_load: begin
                case (f3)
                    3'd0: op = cpu_pkg::op_lb;
                    3'd1: op = cpu_pkg::op_lh;
                    3'd2: op = cpu_pkg::op_lw;
                    3'd4: op = cpu_pkg::op_lbu;
                    3'd5: op = cpu_pkg::op_lhu;
                    default: valid = 1'b0;
                endcase
            end
            cpu_pkg::opc_store: begin
                imm = imm_s;
                case (f3)
                    3'd0: op = cpu_pkg::op_sb;
                    3'd1: op = cpu_pkg::op_sh;
                    3'd2: op = cpu_pkg::op_sw;
                    default: valid = 1'b0;
                endcase
            end
            cpu_pkg::opc_imm: begin
                case (f3)
                    3'd0: op = cpu_pkg::op_addi;
                    3'd2: op = cpu_pkg::op_slti;
                    3'd3: op = cpu_pkg::op_sltiu;
                    3'd4: op = cpu_pkg::op_xori;
                    3'd6: op = cpu_pkg::op_ori;
                    3'd7: op = cpu_pkg::op_andi;
                    3'd1: begin
                        op = cpu_pkg::op_slli;
                        valid = f7 == 7'h00;
                    end
                    default: begin
                        op = f7[5] ? cpu_pkg::op_srai : cpu_pkg::op_srli;
                        valid = f7 == 7'h00 || f7 == 7'h20;
                    end
                endcase
            end
            cpu_pkg::opc_reg: begin
                case ({f7, f3})
                    {7'h00, 3'd0}: op = cpu_pkg::op_add;
                    {7'h20, 3'd0}: op = cpu_pkg::op_sub;
                    {7'h00, 3'd1}: op = cpu_pkg::op_sll;
                    {7'h00, 3'd2}: op = cpu_pkg::op_slt;
                    {7'h00, 3'd3}: op = cpu_pkg::op_sltu;
                    {7'h00, 3'd4}: op = cpu_pkg::op_xor;
                    {7'h00, 3'd5}: op = cpu_pkg::op_srl;
                    {7'h20, 3'd5}: op = cpu_pkg::op_sra;
                    {7'h00, 3'd6}: op = cpu_pkg::op_or;
                    {7'h00, 3'd7}: op = cpu_pkg::op_and;
                    default: valid = 1'b0;
                endcase
            end
            default: valid = 1'b0;
        endcase
        // unknown encodings run as addi x0, x0, 0
        if (!valid) begin
            op = cpu_pkg::op_addi;
            rd = 5'd0;
            rs1 = 5'd0;
            rs2 = 5'd0;
            imm = '0;
        end
    end
endmodule

// ==== verilog/regfile.sv ====
/* register file: 32 registers, two read ports, x0 fixed at zero */
module regfile (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     rdy_in,
    input  logic                     wb_en,
    input  logic [4:0]               rd,
    input  logic [cpu_pkg::xlen-1:0] wb_data,
    input  logic [4:0]               rs1,
    input  logic [4:0]               rs2,
    output logic [cpu_pkg::xlen-1:0] rs1_data,
    output logic [cpu_pkg::xlen-1:0] rs2_data,
    output logic [cpu_pkg::xlen-1:0] dbg_data
);
    logic [cpu_pkg::xlen-1:0] regs [32];

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];
    // a0 for the debug port
    assign dbg_data = regs[10];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdy_in && wb_en && rd != 5'd0) begin
            regs[rd] <= wb_data;
        end
    end
endmodule

// ==== verilog/execute.sv ====
/* execute stage: alu, branch decision, jump target,
   load/store request and load extension at write-back */
module execute (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     rdy_in,
    input  logic                     exec_en,
    input  logic                     commit,
    input  cpu_pkg::op_t             op,
    input  logic [cpu_pkg::xlen-1:0] pc,
    input  logic [cpu_pkg::xlen-1:0] imm,
    input  logic [cpu_pkg::xlen-1:0] rs1_data,
    input  logic [cpu_pkg::xlen-1:0] rs2_data,
    input  logic                     ls_done,
    input  logic [cpu_pkg::xlen-1:0] ls_rdata,
    output logic                     mem_op,
    output logic [cpu_pkg::xlen-1:0] next_pc,
    output logic                     wb_en,
    output logic [cpu_pkg::xlen-1:0] wb_data,
    output logic                     ls_en,
    output logic                     ls_wr,
    output cpu_pkg::len_t            ls_len,
    output logic [cpu_pkg::xlen-1:0] ls_addr,
    output logic [cpu_pkg::xlen-1:0] ls_data
);
    cpu_pkg::op_t             ld_op;
    logic                     is_reg;
    logic                     is_load;
    logic                     is_store;
    logic                     is_branch;
    logic                     taken;
    logic [cpu_pkg::xlen-1:0] opb;
    logic [cpu_pkg::xlen-1:0] pc_inc;
    logic [cpu_pkg::xlen-1:0] pc_imm;
    logic [cpu_pkg::xlen-1:0] res;
    logic [cpu_pkg::xlen-1:0] ld_val;

    assign is_reg = op inside {cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_sll,
                               cpu_pkg::op_slt, cpu_pkg::op_sltu, cpu_pkg::op_xor,
                               cpu_pkg::op_srl, cpu_pkg::op_sra, cpu_pkg::op_or,
                               cpu_pkg::op_and};
    assign is_load = op inside {cpu_pkg::op_lb, cpu_pkg::op_lh, cpu_pkg::op_lw,
                                cpu_pkg::op_lbu, cpu_pkg::op_lhu};
    assign is_store = op inside {cpu_pkg::op_sb, cpu_pkg::op_sh, cpu_pkg::op_sw};
    assign is_branch = op inside {cpu_pkg::op_beq, cpu_pkg::op_bne, cpu_pkg::op_blt,
                                  cpu_pkg::op_bge, cpu_pkg::op_bltu, cpu_pkg::op_bgeu};
    assign opb = is_reg ? rs2_data : imm;
    assign pc_inc = pc + 32'd4;
    assign pc_imm = pc + imm;

    always_comb begin
        case (op)
            cpu_pkg::op_lui: res = imm;
            cpu_pkg::op_auipc: res = pc_imm;
            cpu_pkg::op_jal, cpu_pkg::op_jalr: res = pc_inc;
            cpu_pkg::op_add, cpu_pkg::op_addi: res = rs1_data + opb;
            cpu_pkg::op_sub: res = rs1_data - rs2_data;
            cpu_pkg::op_sll, cpu_pkg::op_slli: res = rs1_data << opb[4:0];
            cpu_pkg::op_slt, cpu_pkg::op_slti: res = {31'd0, $signed(rs1_data) < $signed(opb)};
            cpu_pkg::op_sltu, cpu_pkg::op_sltiu: res = {31'd0, rs1_data < opb};
            cpu_pkg::op_xor, cpu_pkg::op_xori: res = rs1_data ^ opb;
            cpu_pkg::op_srl, cpu_pkg::op_srli: res = rs1_data >> opb[4:0];
            cpu_pkg::op_sra, cpu_pkg::op_srai: res = $signed(rs1_data) >>> opb[4:0];
            cpu_pkg::op_or, cpu_pkg::op_ori: res = rs1_data | opb;
            cpu_pkg::op_and, cpu_pkg::op_andi: res = rs1_data & opb;
            default: res = '0;
        endcase
    end

    always_comb begin
        case (op)
            cpu_pkg::op_beq: taken = rs1_data == rs2_data;
            cpu_pkg::op_bne: taken = rs1_data != rs2_data;
            cpu_pkg::op_blt: taken = $signed(rs1_data) < $signed(rs2_data);
            cpu_pkg::op_bge: taken = $signed(rs1_data) >= $signed(rs2_data);
            cpu_pkg::op_bltu: taken = rs1_data < rs2_data;
            cpu_pkg::op_bgeu: taken = rs1_data >= rs2_data;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (op == cpu_pkg::op_jal || taken) begin
            next_pc = pc_imm;
        end else if (op == cpu_pkg::op_jalr) begin
            next_pc = (rs1_data + imm) & ~32'd1;
        end else begin
            next_pc = pc_inc;
        end
    end

    // memory request goes out with the exec strobe
    assign mem_op = is_load || is_store;
    assign ls_en = exec_en && mem_op;
    assign ls_wr = is_store;
    assign ls_addr = rs1_data + imm;
    assign ls_data = rs2_data;

    always_comb begin
        case (op)
            cpu_pkg::op_lb, cpu_pkg::op_lbu, cpu_pkg::op_sb: ls_len = cpu_pkg::len_b;
            cpu_pkg::op_lh, cpu_pkg::op_lhu, cpu_pkg::op_sh: ls_len = cpu_pkg::len_h;
            default: ls_len = cpu_pkg::len_w;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            ld_op <= cpu_pkg::op_lw;
        end else if (rdy_in && exec_en && is_load) begin
            ld_op <= op;
        end
    end

    // raw bytes arrive zero-extended, signed loads widen here
    always_comb begin
        case (ld_op)
            cpu_pkg::op_lb: ld_val = {{24{ls_rdata[7]}}, ls_rdata[7:0]};
            cpu_pkg::op_lh: ld_val = {{16{ls_rdata[15]}}, ls_rdata[15:0]};
            default: ld_val = ls_rdata;
        endcase
    end

    assign wb_en = commit && !is_store && !is_branch;
    assign wb_data = ls_done ? ld_val : res;
endmodule

// ==== verilog/cpu.sv ====
/* cpu top level: memory controller, fetcher, decoder,
   register file and execute stage on the byte memory bus */
module cpu (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     rdy_in,
    input  logic [7:0]               mem_din,
    input  logic                     io_buffer_full,
    output logic [7:0]               mem_dout,
    output logic [cpu_pkg::xlen-1:0] mem_a,
    output logic                     mem_wr,
    output logic [cpu_pkg::xlen-1:0] dbgreg_dout
);
    // fetch port
    logic                     if_en;
    logic [cpu_pkg::xlen-1:0] if_addr;
    logic                     if_done;
    logic [cpu_pkg::xlen-1:0] if_inst;
    // load/store port
    logic                     ls_en;
    logic                     ls_wr;
    cpu_pkg::len_t            ls_len;
    logic [cpu_pkg::xlen-1:0] ls_addr;
    logic [cpu_pkg::xlen-1:0] ls_data;
    logic                     ls_done;
    logic [cpu_pkg::xlen-1:0] ls_rdata;
    // sequencing
    cpu_pkg::inst_u           inst;
    logic [cpu_pkg::xlen-1:0] pc;
    logic                     exec_en;
    logic                     commit;
    logic                     mem_op;
    logic [cpu_pkg::xlen-1:0] next_pc;
    // decode and operands
    cpu_pkg::op_t             op;
    logic [4:0]               rd;
    logic [4:0]               rs1;
    logic [4:0]               rs2;
    logic [cpu_pkg::xlen-1:0] imm;
    logic [cpu_pkg::xlen-1:0] rs1_data;
    logic [cpu_pkg::xlen-1:0] rs2_data;
    logic                     wb_en;
    logic [cpu_pkg::xlen-1:0] wb_data;

    memctrl memctrl (
        .clk_in, .reset, .rdy_in, .io_buffer_full,
        .mem_din, .mem_dout, .mem_a, .mem_wr,
        .if_en, .if_addr, .if_done, .if_inst,
        .ls_en, .ls_wr, .ls_len, .ls_addr, .ls_data, .ls_done, .ls_rdata
    );

    fetcher fetcher (
        .clk_in, .reset, .rdy_in,
        .if_done, .if_inst, .ls_done, .mem_op, .next_pc,
        .if_en, .if_addr, .inst, .pc, .exec_en, .commit
    );

    decoder decoder (
        .inst, .op, .rd, .rs1, .rs2, .imm
    );

    regfile regfile (
        .clk_in, .reset, .rdy_in,
        .wb_en, .rd, .wb_data, .rs1, .rs2,
        .rs1_data, .rs2_data, .dbg_data(dbgreg_dout)
    );

    execute execute (
        .clk_in, .reset, .rdy_in, .exec_en, .commit,
        .op, .pc, .imm, .rs1_data, .rs2_data, .ls_done, .ls_rdata,
        .mem_op, .next_pc, .wb_en, .wb_data,
        .ls_en, .ls_wr, .ls_len, .ls_addr, .ls_data
    );
endmodule

// ==== sim/ram_model.sv ====
/* byte memory model with next-cycle read data,
   capture of the i/o output port and the stop write */
module ram_model (
    input  logic                     clk_in,
    input  logic [cpu_pkg::xlen-1:0] mem_a,
    input  logic [7:0]               mem_dout,
    input  logic                     mem_wr,
    output logic [7:0]               mem_din,
    output logic                     io_valid,
    output logic [7:0]               io_data,
    output logic                     io_stop_hit
);
    logic [7:0] mem [131072];

    initial begin
        // background pattern so stray reads are recognizable
        for (int a = 0; a < 131072; a++) begin
            mem[17'(a)] = 8'(a ^ (a >> 8) ^ (a >> 16));
        end
        $readmemh("sim/prog.hex", mem);
        mem_din = 8'd0;
        io_valid = 1'b0;
        io_stop_hit = 1'b0;
        io_data = 8'd0;
    end

    always @(posedge clk_in) begin
        mem_din <= mem[mem_a[16:0]];
        io_valid <= 1'b0;
        io_stop_hit <= 1'b0;
        if (mem_wr) begin
            if (mem_a[17:16] == 2'b11) begin
                if (mem_a == cpu_pkg::io_base) begin
                    io_valid <= 1'b1;
                    io_data <= mem_dout;
                end else if (mem_a == cpu_pkg::io_stop) begin
                    io_stop_hit <= 1'b1;
                end
            end else begin
                mem[mem_a[16:0]] <= mem_dout;
            end
        end
    end
endmodule

// ==== sim/cpu_checker.sv ====
/* concurrent assertions on the memory bus,
   bound into the memory controller */
module cpu_checker (
    input logic                     clk_in,
    input logic                     reset,
    input logic                     rdy_in,
    input logic                     io_buffer_full,
    input logic                     mem_wr,
    input logic [cpu_pkg::xlen-1:0] mem_a,
    input logic                     if_done,
    input logic                     ls_done
);
    int fail_count = 0;

    // no write may happen while the bus is paused
    wr_while_paused: assert property (@(posedge clk_in) disable iff (reset)
        !(mem_wr && !rdy_in))
    else begin
        $error("mem_wr high while rdy_in is low");
        fail_count++;
    end

    wr_into_full_buffer: assert property (@(posedge clk_in) disable iff (reset)
        !(mem_wr && io_buffer_full && mem_a == cpu_pkg::io_base))
    else begin
        $error("output write while io_buffer_full is high");
        fail_count++;
    end

    both_done: assert property (@(posedge clk_in) disable iff (reset)
        !(if_done && ls_done))
    else begin
        $error("if_done and ls_done high together");
        fail_count++;
    end
endmodule

bind memctrl cpu_checker checker_i (
    .clk_in(clk_in),
    .reset(reset),
    .rdy_in(rdy_in),
    .io_buffer_full(io_buffer_full),
    .mem_wr(mem_wr),
    .mem_a(mem_a),
    .if_done(if_done),
    .ls_done(ls_done)
);

// ==== sim/cpu_tb.sv ====
/* cpu testbench: clock, reset, stall stimulus, reference
   byte sequence and the process that compares the output port */
module cpu_tb;
    // about four times the three runs together with their random stalls
    localparam int timeout_cycles = 20000;
    localparam int reset_cycles = 16;

    logic                     clk_in = 1'b0;
    logic                     reset;
    logic                     rdy_in;
    logic                     io_buffer_full;
    logic [7:0]               mem_din;
    logic [7:0]               mem_dout;
    logic [cpu_pkg::xlen-1:0] mem_a;
    logic                     mem_wr;
    logic [cpu_pkg::xlen-1:0] dbgreg_dout;
    logic                     io_valid;
    logic [7:0]               io_data;
    logic                     io_stop_hit;

    logic [31:0] words [$];
    logic [7:0]  expected [$];
    logic [31:0] ref_sum;
    int          stall_mode = 0;
    int          out_idx = 0;
    int          error_count = 0;
    int          cycle_count = 0;
    int          tests_failed = 0;
    logic        stop_seen = 1'b0;

    cpu UUT (
        .clk_in(clk_in),
        .reset(reset),
        .rdy_in(rdy_in),
        .mem_din(mem_din),
        .io_buffer_full(io_buffer_full),
        .mem_dout(mem_dout),
        .mem_a(mem_a),
        .mem_wr(mem_wr),
        .dbgreg_dout(dbgreg_dout)
    );

    ram_model ram (
        .clk_in(clk_in),
        .mem_a(mem_a),
        .mem_dout(mem_dout),
        .mem_wr(mem_wr),
        .mem_din(mem_din),
        .io_valid(io_valid),
        .io_data(io_data),
        .io_stop_hit(io_stop_hit)
    );

    always #50 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timed out after %0d cycles without the stop write", timeout_cycles);
            $display("Errors found");
            $finish;
        end
    end

    function automatic void push_word(input logic [31:0] w);
        for (int b = 0; b < 4; b++) begin
            expected.push_back(w[8*b +: 8]);
        end
    endfunction

    // output bytes of the test program, in write order
    function automatic void build_expected();
        logic [31:0] max_w;
        logic [7:0]  b3;
        logic [15:0] h;
        ref_sum = 32'd0;
        max_w = 32'd0;
        foreach (words[i]) begin
            ref_sum = ref_sum + words[i];
            if (words[i] > max_w) max_w = words[i];
        end
        // byte 0x1003 and halfword 0x1002 sit in the top of word 0
        b3 = words[0][31:24];
        h = words[0][31:16];
        expected.delete();
        push_word(ref_sum);
        push_word(max_w);
        push_word({{24{b3[7]}}, b3});
        push_word({24'd0, b3});
        push_word({{16{h[15]}}, h});
        push_word({16'd0, h});
        expected.push_back(8'd8);
    endfunction

    // stall stimulus on the falling edge
    always @(negedge clk_in) begin
        rdy_in = 1'b1;
        io_buffer_full = 1'b0;
        if (!reset && stall_mode == 1) rdy_in = ($urandom % 100) >= 30;
        if (!reset && stall_mode == 2) io_buffer_full = ($urandom % 100) < 40;
    end

    // compares each output byte as it arrives
    always @(negedge clk_in) begin
        if (!reset && io_valid) begin
            if (out_idx >= expected.size()) begin
                $display("%0t: extra output byte %02h after all %0d expected bytes",
                         $time, io_data, expected.size());
                error_count++;
            end else if (io_data != expected[out_idx]) begin
                $display("[FAIL] %0t io_data[%0d]: got %02h expected %02h",
                         $time, out_idx, io_data, expected[out_idx]);
                error_count++;
            end
            out_idx++;
        end
        if (!reset && io_stop_hit) stop_seen = 1'b1;
    end

    task automatic load_data();
        logic [16:0] a;
        for (int i = 0; i < 8; i++) begin
            for (int b = 0; b < 4; b++) begin
                a = 17'h1000 + 17'(4 * i + b);
                ram.mem[a] = words[i][8*b +: 8];
            end
        end
    endtask

    task automatic run_test(input int mode, input string name);
        int errs_before;
        errs_before = error_count;
        @(negedge clk_in);
        reset = 1'b1;
        stall_mode = mode;
        repeat (reset_cycles) @(negedge clk_in);
        out_idx = 0;
        stop_seen = 1'b0;
        reset = 1'b0;
        while (!stop_seen) begin
            @(negedge clk_in);
        end
        // stop must follow the last byte
        if (out_idx != expected.size()) begin
            $display("test %s: %0d output bytes before stop, %0d expected",
                     name, out_idx, expected.size());
            error_count++;
        end
        if (dbgreg_dout != ref_sum) begin
            $display("[FAIL] %0t dbgreg_dout: got %08h expected %08h",
                     $time, dbgreg_dout, ref_sum);
            error_count++;
        end
        if (error_count != errs_before) tests_failed++;
        $display("test %s: %s, %0d errors", name,
                 (error_count == errs_before) ? "ok" : "failed",
                 error_count - errs_before);
    endtask

    initial begin
        void'($urandom(32'haf2a_3986));
        reset = 1'b1;
        rdy_in = 1'b1;
        io_buffer_full = 1'b0;
        for (int i = 0; i < 8; i++) begin
            words.push_back($urandom);
        end
        // word 0 negative so the signed reloads differ from the unsigned ones
        words[0] = words[0] | 32'h8000_0000;
        // word 1 positive to mix signs for the unsigned maximum
        words[1] = words[1] & 32'h7fff_ffff;
        build_expected();
        @(negedge clk_in);
        load_data();
        run_test(0, "plain run");
        run_test(1, "rdy_in pauses");
        run_test(2, "io buffer full");
        error_count += UUT.memctrl.checker_i.fail_count;
        $display("tests 3, failed %0d, errors %0d", tests_failed, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end
endmodule

// ==== sim/prog.hex ====
// test program, one instruction per line as four bytes, little-endian
// columns: byte0 byte1 byte2 byte3 // address and instruction
b7 12 00 00 // 00 lui x5, 0x1
37 06 03 00 // 04 lui x12, 0x30
13 03 80 00 // 08 addi x6, x0, 8
83 a3 02 00 // 0c lw x7, 0(x5)
33 05 75 00 // 10 add x10, x10, x7
63 f4 75 00 // 14 bgeu x11, x7, 0x1c
93 85 03 00 // 18 addi x11, x7, 0
93 82 42 00 // 1c addi x5, x5, 4
93 86 16 00 // 20 addi x13, x13, 1
13 03 f3 ff // 24 addi x6, x6, -1
e3 12 03 fe // 28 bne x6, x0, 0x0c
13 07 05 00 // 2c addi x14, x10, 0
ef 00 c0 03 // 30 jal x1, 0x6c
13 87 05 00 // 34 addi x14, x11, 0
ef 00 40 03 // 38 jal x1, 0x6c
b7 12 00 00 // 3c lui x5, 0x1
03 87 32 00 // 40 lb x14, 3(x5)
ef 00 80 02 // 44 jal x1, 0x6c
03 c7 32 00 // 48 lbu x14, 3(x5)
ef 00 00 02 // 4c jal x1, 0x6c
03 97 22 00 // 50 lh x14, 2(x5)
ef 00 80 01 // 54 jal x1, 0x6c
03 d7 22 00 // 58 lhu x14, 2(x5)
ef 00 00 01 // 5c jal x1, 0x6c
23 00 d6 00 // 60 sb x13, 0(x12)
23 02 06 00 // 64 sb x0, 4(x12)
6f 00 00 00 // 68 jal x0, 0x68
23 00 e6 00 // 6c sb x14, 0(x12)
13 57 87 00 // 70 srli x14, x14, 8
23 00 e6 00 // 74 sb x14, 0(x12)
13 57 87 00 // 78 srli x14, x14, 8
23 00 e6 00 // 7c sb x14, 0(x12)
13 57 87 00 // 80 srli x14, x14, 8
23 00 e6 00 // 84 sb x14, 0(x12)
67 80 00 00 // 88 jalr x0, 0(x1)

// ==== compile.f ====
verilog/cpu_pkg.sv
verilog/memctrl.sv
verilog/fetcher.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/execute.sv
verilog/cpu.sv
sim/ram_model.sv
sim/cpu_checker.sv
sim/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f compile.f --top-module cpu_tb -o cpu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/cpu_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    exit 0
fi
exit 1
